// ==== hdl/axi_pkg.sv ====
package axi_pkg;

    // ============================================================
    // bus widths
    // ============================================================
    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_DATA_WIDTH = 32;
    localparam int AXI_ID_WIDTH   = 4;

    typedef logic [AXI_ID_WIDTH-1:0] axi_id_t;

    // ============================================================
    // response codes
    // ============================================================
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;   // only code this slave returns

endpackage

// ==== hdl/soft_rst_pkg.sv ====
package soft_rst_pkg;

    // ============================================================
    // PE grid and units
    // ============================================================
    localparam int PE_COUNT     = 4;    // 2x2 grid, p = x + 2*y
    localparam int UNITS_PER_PE = 8;
    localparam int RST_COUNT    = PE_COUNT * UNITS_PER_PE;

    // address order inside one element
    typedef enum logic [2:0] {
        UNIT_DISPATCHER,
        UNIT_REGULAR_0,
        UNIT_REGULAR_1,
        UNIT_DSA_0,
        UNIT_DSA_1,
        UNIT_DSA_2,
        UNIT_NOU,
        UNIT_SRAM
    } unit_e;

    typedef logic [$clog2(RST_COUNT)-1:0] rst_idx_t;   // p*8 + unit

    // ============================================================
    // register map
    // ============================================================
    localparam int PE_STRIDE   = 64;
    localparam int UNIT_STRIDE = 4;
    localparam int REG_SPAN    = 256;

    // field positions in the byte address
    localparam int UNIT_LSB = $clog2(UNIT_STRIDE);
    localparam int GAP_LSB  = $clog2(UNIT_STRIDE * UNITS_PER_PE);   // hole above the units
    localparam int PE_LSB   = $clog2(PE_STRIDE);
    localparam int PE_BITS  = $clog2(PE_COUNT);

    // pulse
    localparam int RST_PULSE_CYCLES = 4;
    typedef logic [$clog2(RST_PULSE_CYCLES+1)-1:0] pulse_cnt_t;

    localparam logic [31:0] UNMAPPED_RDATA = 32'hbadca11;

endpackage

// ==== hdl/reg_access_if.sv ====
interface reg_access_if;
    import axi_pkg::*;

    // write strobe, one cycle per accepted W beat
    logic                      wr_en;
    logic [AXI_ADDR_WIDTH-1:0] wr_addr;
    logic [AXI_DATA_WIDTH-1:0] wr_data;

    // read strobe, data comes back in the same cycle
    logic                      rd_en;
    logic [AXI_ADDR_WIDTH-1:0] rd_addr;
    logic [AXI_DATA_WIDTH-1:0] rd_data;

    modport wr_port (
        output wr_en, wr_addr, wr_data
    );

    modport rd_port (
        output rd_en, rd_addr,
        input  rd_data
    );

    modport bank (
        input  wr_en, wr_addr, wr_data,
        input  rd_en, rd_addr,
        output rd_data
    );

endinterface

// ==== hdl/axi_wr_slave.sv ====
module axi_wr_slave (
    input  logic                               sys_clk,
    input  logic                               sys_rstn,

    input  axi_pkg::axi_id_t                   awid,
    input  logic [axi_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                               awvalid,
    output logic                               awready,

    input  logic [axi_pkg::AXI_DATA_WIDTH-1:0] wdata,
    input  logic                               wvalid,
    output logic                               wready,

    output axi_pkg::axi_id_t                   bid,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,

    reg_access_if.wr_port                      acc
);
    import axi_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e                 state;
    wr_state_e                 state_nxt;
    logic [AXI_ADDR_WIDTH-1:0] addr_q;

    // ============================================================
    // state machine
    // ============================================================
    always_ff @(posedge sys_clk or negedge sys_rstn) begin
        if (!sys_rstn) begin
            state <= WR_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            WR_IDLE: if (awvalid) state_nxt = WR_DATA;
            WR_DATA: if (wvalid)  state_nxt = WR_RESP;
            WR_RESP: if (bready)  state_nxt = WR_IDLE;
            default: state_nxt = WR_IDLE;
        endcase
    end

    // address and id held for the whole transaction
    always_ff @(posedge sys_clk) begin
        if (awvalid && awready) begin
            addr_q <= awaddr;
            bid    <= awid;
        end
    end

    assign awready = (state == WR_IDLE);
    assign wready  = (state == WR_DATA);
    assign bvalid  = (state == WR_RESP);
    assign bresp   = AXI_RESP_OKAY;

    // ============================================================
    // bank side
    // ============================================================
    assign acc.wr_en   = wready && wvalid;   // W handshake
    assign acc.wr_addr = addr_q;
    assign acc.wr_data = wdata;

    // response must wait for the master
    a_b_hold: assert property (@(posedge sys_clk) disable iff (!sys_rstn)
        bvalid && !bready |=> bvalid && $stable(bid));

endmodule

// ==== hdl/axi_rd_slave.sv ====
module axi_rd_slave (
    input  logic                               sys_clk,
    input  logic                               sys_rstn,

    input  axi_pkg::axi_id_t                   arid,
    input  logic [axi_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                               arvalid,
    output logic                               arready,

    output axi_pkg::axi_id_t                   rid,
    output logic [axi_pkg::AXI_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready,

    reg_access_if.rd_port                      acc
);
    import axi_pkg::*;

    typedef enum logic {
        RD_IDLE,
        RD_RESP
    } rd_state_e;

    rd_state_e state;
    rd_state_e state_nxt;

    always_ff @(posedge sys_clk or negedge sys_rstn) begin
        if (!sys_rstn) begin
            state <= RD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            RD_IDLE: if (arvalid) state_nxt = RD_RESP;
            RD_RESP: if (rready)  state_nxt = RD_IDLE;
            default: state_nxt = RD_IDLE;
        endcase
    end

    // bank is looked up during the AR handshake
    assign acc.rd_en   = arvalid && arready;
    assign acc.rd_addr = araddr;

    always_ff @(posedge sys_clk) begin
        if (acc.rd_en) begin
            rdata <= acc.rd_data;
            rid   <= arid;
        end
    end

    assign arready = (state == RD_IDLE);
    assign rvalid  = (state == RD_RESP);
    assign rresp   = AXI_RESP_OKAY;

    a_r_hold: assert property (@(posedge sys_clk) disable iff (!sys_rstn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid));

endmodule

// ==== hdl/soft_rst_regs.sv ====
module soft_rst_regs (
    input  logic                                  sys_clk,
    input  logic                                  sys_rstn,
    reg_access_if.bank                            acc,
    output logic [soft_rst_pkg::RST_COUNT-1:0]    soft_rstn
);
    import axi_pkg::*;
    import soft_rst_pkg::*;

    pulse_cnt_t           pulse_cnt [RST_COUNT];
    logic [RST_COUNT-1:0] load;

    // ============================================================
    // address decode
    // ============================================================
    // word aligned, below the span, nothing in the hole above the units
    function automatic logic addr_hit(input logic [AXI_ADDR_WIDTH-1:0] addr);
        return (addr < REG_SPAN) &&
               (addr[UNIT_LSB-1:0] == '0) &&
               (addr[PE_LSB-1:GAP_LSB] == '0);
    endfunction

    function automatic rst_idx_t addr_idx(input logic [AXI_ADDR_WIDTH-1:0] addr);
        logic [PE_BITS-1:0] pe;
        unit_e              unit;
        pe   = addr[PE_LSB +: PE_BITS];
        unit = unit_e'(addr[UNIT_LSB +: $bits(unit_e)]);
        return {pe, unit};
    endfunction

    // only a 1 in bit 0 starts a pulse
    always_comb begin
        load = '0;
        if (acc.wr_en && addr_hit(acc.wr_addr) && acc.wr_data[0]) begin
            load[addr_idx(acc.wr_addr)] = 1'b1;
        end
    end

    // ============================================================
    // pulse counters
    // ============================================================
    always_ff @(posedge sys_clk or negedge sys_rstn) begin
        if (!sys_rstn) begin
            for (int i = 0; i < RST_COUNT; i++) begin
                pulse_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RST_COUNT; i++) begin
                if (load[i]) begin
                    pulse_cnt[i] <= pulse_cnt_t'(RST_PULSE_CYCLES);   // restart on rewrite
                end else if (pulse_cnt[i] != '0) begin
                    pulse_cnt[i] <= pulse_cnt[i] - 1'b1;
                end
            end
        end
    end

    for (genvar g = 0; g < RST_COUNT; g++) begin : g_rst
        assign soft_rstn[g] = (pulse_cnt[g] == '0);

        a_cnt_max: assert property (@(posedge sys_clk) disable iff (!sys_rstn)
            pulse_cnt[g] <= RST_PULSE_CYCLES);
    end

    // ============================================================
    // read mux
    // ============================================================
    always_comb begin
        acc.rd_data = '0;   // quiet when no read is strobed
        if (acc.rd_en) begin
            if (addr_hit(acc.rd_addr)) begin
                acc.rd_data = AXI_DATA_WIDTH'(pulse_cnt[addr_idx(acc.rd_addr)] != '0);
            end else begin
                acc.rd_data = UNMAPPED_RDATA;
            end
        end
    end

endmodule

// ==== hdl/soft_rst_top.sv ====
module soft_rst_top (
    input  logic                                   sys_clk,
    input  logic                                   sys_rstn,

    // write address / data / response
    input  axi_pkg::axi_id_t                       axi_awid,
    input  logic [axi_pkg::AXI_ADDR_WIDTH-1:0]     axi_awaddr,
    input  logic                                   axi_awvalid,
    output logic                                   axi_awready,
    input  logic [axi_pkg::AXI_DATA_WIDTH-1:0]     axi_wdata,
    input  logic [axi_pkg::AXI_DATA_WIDTH/8-1:0]   axi_wstrb,    // accepted, not used
    input  logic                                   axi_wvalid,
    output logic                                   axi_wready,
    output axi_pkg::axi_id_t                       axi_bid,
    output logic [1:0]                             axi_bresp,
    output logic                                   axi_bvalid,
    input  logic                                   axi_bready,

    // read address / data
    input  axi_pkg::axi_id_t                       axi_arid,
    input  logic [axi_pkg::AXI_ADDR_WIDTH-1:0]     axi_araddr,
    input  logic                                   axi_arvalid,
    output logic                                   axi_arready,
    output axi_pkg::axi_id_t                       axi_rid,
    output logic [axi_pkg::AXI_DATA_WIDTH-1:0]     axi_rdata,
    output logic [1:0]                             axi_rresp,
    output logic                                   axi_rvalid,
    input  logic                                   axi_rready,

    output logic [soft_rst_pkg::RST_COUNT-1:0]     soft_rstn
);

    reg_access_if acc ();

    axi_wr_slave u_wr (
        .sys_clk  (sys_clk),
        .sys_rstn (sys_rstn),
        .awid     (axi_awid),
        .awaddr   (axi_awaddr),
        .awvalid  (axi_awvalid),
        .awready  (axi_awready),
        .wdata    (axi_wdata),
        .wvalid   (axi_wvalid),
        .wready   (axi_wready),
        .bid      (axi_bid),
        .bresp    (axi_bresp),
        .bvalid   (axi_bvalid),
        .bready   (axi_bready),
        .acc      (acc.wr_port)
    );

    axi_rd_slave u_rd (
        .sys_clk  (sys_clk),
        .sys_rstn (sys_rstn),
        .arid     (axi_arid),
        .araddr   (axi_araddr),
        .arvalid  (axi_arvalid),
        .arready  (axi_arready),
        .rid      (axi_rid),
        .rdata    (axi_rdata),
        .rresp    (axi_rresp),
        .rvalid   (axi_rvalid),
        .rready   (axi_rready),
        .acc      (acc.rd_port)
    );

    // counters and decode
    soft_rst_regs u_regs (
        .sys_clk   (sys_clk),
        .sys_rstn  (sys_rstn),
        .acc       (acc.bank),
        .soft_rstn (soft_rstn)
    );

endmodule

// ==== testbench/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic sys_clk,
    output logic sys_rstn
);

    localparam int HALF_PERIOD = 2;
    localparam int RST_CYCLES  = 5;

    initial begin
        sys_clk = 1'b0;
        forever #(HALF_PERIOD) sys_clk = ~sys_clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        sys_rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge sys_clk);
        #1 sys_rstn = 1'b1;
    end

endmodule

// ==== testbench/soft_rst_tb.sv ====
module soft_rst_tb;
    import axi_pkg::*;
    import soft_rst_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int ENTRY_COUNT    = 17;
    localparam int TIMEOUT_CYCLES = ENTRY_COUNT * 40 + 100;

    typedef enum {OP_WR, OP_RD, OP_WR_RD} op_e;   // OP_WR_RD reads back while the pulse runs

    typedef struct {
        op_e         op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        bit          exp_pulse;
    } entry_t;

    logic                      sys_clk;
    logic                      sys_rstn;
    axi_id_t                   axi_awid;
    logic [AXI_ADDR_WIDTH-1:0] axi_awaddr;
    logic                      axi_awvalid;
    logic                      axi_awready;
    logic [AXI_DATA_WIDTH-1:0] axi_wdata;
    logic [3:0]                axi_wstrb;
    logic                      axi_wvalid;
    logic                      axi_wready;
    axi_id_t                   axi_bid;
    logic [1:0]                axi_bresp;
    logic                      axi_bvalid;
    logic                      axi_bready;
    axi_id_t                   axi_arid;
    logic [AXI_ADDR_WIDTH-1:0] axi_araddr;
    logic                      axi_arvalid;
    logic                      axi_arready;
    axi_id_t                   axi_rid;
    logic [AXI_DATA_WIDTH-1:0] axi_rdata;
    logic [1:0]                axi_rresp;
    logic                      axi_rvalid;
    logic                      axi_rready;
    logic [RST_COUNT-1:0]      soft_rstn;

    entry_t stim [ENTRY_COUNT];
    int     error_count = 0;
    int     check_count = 0;

    tb_clk_gen clk_gen0 (.sys_clk(sys_clk), .sys_rstn(sys_rstn));

    soft_rst_top dut0 (
        .sys_clk     (sys_clk),
        .sys_rstn    (sys_rstn),
        .axi_awid    (axi_awid),
        .axi_awaddr  (axi_awaddr),
        .axi_awvalid (axi_awvalid),
        .axi_awready (axi_awready),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready),
        .axi_bid     (axi_bid),
        .axi_bresp   (axi_bresp),
        .axi_bvalid  (axi_bvalid),
        .axi_bready  (axi_bready),
        .axi_arid    (axi_arid),
        .axi_araddr  (axi_araddr),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_rid     (axi_rid),
        .axi_rdata   (axi_rdata),
        .axi_rresp   (axi_rresp),
        .axi_rvalid  (axi_rvalid),
        .axi_rready  (axi_rready),
        .soft_rstn   (soft_rstn)
    );

    // ============================================================
    // helpers
    // ============================================================
    task automatic next_cycle();
        @(posedge sys_clk);
        #1;   // drive and sample point
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s: got 0x%08h, expected 0x%08h (t=%0t)", name, got, exp, $time);
        end
    endtask

    // element base plus unit offset, per the register map
    function automatic int expected_idx(input logic [31:0] addr);
        return (addr / PE_STRIDE) * UNITS_PER_PE + (addr % PE_STRIDE) / UNIT_STRIDE;
    endfunction

    task automatic send_aw(input axi_id_t id, input logic [31:0] addr);
        logic hs;
        axi_awid    = id;
        axi_awaddr  = addr;
        axi_awvalid = 1'b1;
        do begin
            hs = axi_awready;
            next_cycle();
        end while (!hs);
        axi_awvalid = 1'b0;
    endtask

    task automatic send_w(input logic [31:0] data);
        logic hs;
        repeat ($urandom_range(3, 0)) next_cycle();   // late W beat
        axi_wdata  = data;
        axi_wvalid = 1'b1;
        do begin
            hs = axi_wready;
            next_cycle();
        end while (!hs);
        axi_wvalid = 1'b0;
    endtask

    task automatic take_b(input axi_id_t id);
        int hold;
        hold = $urandom_range(3, 0);
        check_val("bvalid", axi_bvalid, 1'b1);   // one cycle after W
        repeat (hold) begin
            check_val("bvalid", axi_bvalid, 1'b1);
            check_val("bid", axi_bid, id);
            next_cycle();
        end
        check_val("bid", axi_bid, id);
        check_val("bresp", axi_bresp, AXI_RESP_OKAY);
        axi_bready = 1'b1;
        next_cycle();
        axi_bready = 1'b0;
        check_val("bvalid", axi_bvalid, 1'b0);
        check_val("awready", axi_awready, 1'b1);
    endtask

    task automatic read_beat(input axi_id_t id, input logic [31:0] addr, input logic [31:0] exp);
        int   hold;
        logic hs;
        hold        = $urandom_range(3, 0);
        axi_arid    = id;
        axi_araddr  = addr;
        axi_arvalid = 1'b1;
        do begin
            hs = axi_arready;
            next_cycle();
        end while (!hs);
        axi_arvalid = 1'b0;
        check_val("rvalid", axi_rvalid, 1'b1);
        repeat (hold) begin   // rready held low
            check_val("rvalid", axi_rvalid, 1'b1);
            check_val("rdata", axi_rdata, exp);
            check_val("rid", axi_rid, id);
            next_cycle();
        end
        check_val("rdata", axi_rdata, exp);
        check_val("rid", axi_rid, id);
        check_val("rresp", axi_rresp, AXI_RESP_OKAY);
        axi_rready = 1'b1;
        next_cycle();
        axi_rready = 1'b0;
        check_val("rvalid", axi_rvalid, 1'b0);
        check_val("arready", axi_arready, 1'b1);
    endtask

    // starts at the first sample after the W transfer
    task automatic watch_pulse(input logic [31:0] addr, input bit exp_pulse);
        logic [31:0] exp_rstn;
        exp_rstn = exp_pulse ? ~(32'd1 << expected_idx(addr)) : '1;
        repeat (RST_PULSE_CYCLES) begin
            check_val("soft_rstn", soft_rstn, exp_rstn);
            next_cycle();
        end
        check_val("soft_rstn", soft_rstn, '1);
    endtask

    // ============================================================
    // stimulus table
    // ============================================================
    task automatic load_table();
        stim[0]  = '{OP_WR_RD, 32'h0000_0000, 32'h0000_0001, 32'h1, 1'b1};   // pe0 dispatcher
        stim[1]  = '{OP_RD,    32'h0000_0000, 32'h0,         32'h0, 1'b0};
        stim[2]  = '{OP_WR,    32'h0000_001c, 32'h0000_0001, 32'h0, 1'b1};   // pe0 sram
        stim[3]  = '{OP_WR_RD, 32'h0000_0048, 32'h0000_0003, 32'h1, 1'b1};   // pe1 regular 1
        stim[4]  = '{OP_RD,    32'h0000_0048, 32'h0,         32'h0, 1'b0};
        stim[5]  = '{OP_WR,    32'h0000_008c, 32'hffff_ffff, 32'h0, 1'b1};   // pe2 dsa 0
        stim[6]  = '{OP_WR_RD, 32'h0000_00d8, 32'h0000_0001, 32'h1, 1'b1};   // pe3 nou
        stim[7]  = '{OP_WR,    32'h0000_00d4, 32'h0000_0001, 32'h0, 1'b1};   // pe3 dsa 2
        stim[8]  = '{OP_WR_RD, 32'h0000_0044, 32'h0000_0002, 32'h0, 1'b0};   // bit 0 clear
        stim[9]  = '{OP_WR,    32'h0000_0090, 32'h0000_0000, 32'h0, 1'b0};
        stim[10] = '{OP_WR_RD, 32'h0000_0020, 32'h0000_0001, UNMAPPED_RDATA, 1'b0};   // hole
        stim[11] = '{OP_WR,    32'h0000_0006, 32'h0000_0001, 32'h0, 1'b0};   // unaligned
        stim[12] = '{OP_WR,    32'h0000_0100, 32'h0000_0001, 32'h0, 1'b0};   // past the span
        stim[13] = '{OP_RD,    32'h0000_0100, 32'h0,         UNMAPPED_RDATA, 1'b0};
        stim[14] = '{OP_RD,    32'h0000_007e, 32'h0,         UNMAPPED_RDATA, 1'b0};
        stim[15] = '{OP_RD,    32'h1000_0000, 32'h0,         UNMAPPED_RDATA, 1'b0};
        stim[16] = '{OP_RD,    32'h0000_00d8, 32'h0,         32'h0, 1'b0};
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        axi_id_t w_id;
        axi_id_t r_id;
        void'($urandom(70));
        axi_awid    = '0;
        axi_awaddr  = '0;
        axi_awvalid = 1'b0;
        axi_wdata   = '0;
        axi_wstrb   = 4'hf;
        axi_wvalid  = 1'b0;
        axi_bready  = 1'b0;
        axi_arid    = '0;
        axi_araddr  = '0;
        axi_arvalid = 1'b0;
        axi_rready  = 1'b0;
        load_table();

        @(posedge sys_rstn);
        next_cycle();
        check_val("soft_rstn", soft_rstn, '1);
        check_val("awready", axi_awready, 1'b1);
        check_val("arready", axi_arready, 1'b1);
        check_val("wready", axi_wready, 1'b0);
        check_val("bvalid", axi_bvalid, 1'b0);
        check_val("rvalid", axi_rvalid, 1'b0);

        for (int i = 0; i < ENTRY_COUNT; i++) begin
            w_id = axi_id_t'($urandom_range(15, 0));
            r_id = axi_id_t'($urandom_range(15, 0));
            check_val("soft_rstn", soft_rstn, '1);   // previous pulse over
            case (stim[i].op)
                OP_RD: read_beat(r_id, stim[i].addr, stim[i].exp_rdata);
                OP_WR: begin
                    send_aw(w_id, stim[i].addr);
                    send_w(stim[i].wdata);
                    fork
                        take_b(w_id);
                        watch_pulse(stim[i].addr, stim[i].exp_pulse);
                    join
                end
                default: begin
                    send_aw(w_id, stim[i].addr);
                    send_w(stim[i].wdata);
                    fork
                        take_b(w_id);
                        watch_pulse(stim[i].addr, stim[i].exp_pulse);
                        read_beat(r_id, stim[i].addr, stim[i].exp_rdata);
                    join
                end
            endcase
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d clock periods", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/axi_pkg.sv
hdl/soft_rst_pkg.sv
hdl/reg_access_if.sv
hdl/axi_wr_slave.sv
hdl/axi_rd_slave.sv
hdl/soft_rst_regs.sv
hdl/soft_rst_top.sv
testbench/tb_clk_gen.sv
testbench/soft_rst_tb.sv

// ==== Bender.yml ====
package:
  name: soft_rst_ctrl

sources:
  - files:
      - hdl/axi_pkg.sv
      - hdl/soft_rst_pkg.sv
      - hdl/reg_access_if.sv
      - hdl/axi_wr_slave.sv
      - hdl/axi_rd_slave.sv
      - hdl/soft_rst_regs.sv
      - hdl/soft_rst_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/soft_rst_tb.sv
